/* tim.f */
source/tim_pkg.sv
source/tim_ram.sv
source/tim_decode.sv
source/tim_merge.sv
source/tim.sv
verif/tim_asserts.sv
verif/tim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tim_tb \
  -f tim.f \
  -o tim_sim \
  --Mdir obj_dir

./obj_dir/tim_sim 2>&1 | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  echo "simulation passed, see sim.log"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* verif/tim_tb.sv */
`timescale 1ns/100ps

module tim_tb;

  localparam int depth = 64;
  localparam int width = 4;
  localparam int words = depth * width;
  localparam int timeout_cycles = 200;

  typedef struct packed {
    logic is_read;
    logic [63:0] value;
  } expect_type;

  logic clock;
  logic reset;
  logic valid;
  logic [31:0] addr;
  logic [63:0] wdata;
  logic [7:0] wstrb;
  logic [63:0] rdata;
  logic ready;

  logic [63:0] model [words] = '{default: '0};
  expect_type pending [$]; // one entry per request in flight

  string test_name;
  int check_errors = 0;
  int errors_at_start = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  bit timed_out = 1'b0;

  tim #(
    .tim_depth(depth),
    .tim_width(width)
  ) dut (
    .clock(clock),
    .reset(reset),
    .valid(valid),
    .addr(addr),
    .wdata(wdata),
    .wstrb(wstrb),
    .rdata(rdata),
    .ready(ready)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  // responses are stable mid cycle
  always @(negedge clock) begin
    expect_type head;
    if (reset && ready) begin
      assert (pending.size() != 0) else begin
        $display("ready went high in test %s with no request outstanding", test_name);
        check_errors++;
      end
      if (pending.size() != 0) begin
        head = pending.pop_front();
        if (head.is_read) begin
          assert (rdata == head.value) else begin
            $display("FAILED %s expected %h actual %h", test_name, head.value, rdata);
            check_errors++;
          end
        end
      end
    end
  end

  function automatic int word_of(input logic [31:0] a);
    return int'((a >> 3) % words); // byte offset and high bits drop out
  endfunction

  function automatic logic [63:0] apply_strobe(
    input logic [63:0] old_word,
    input logic [63:0] new_word,
    input logic [7:0] strb
  );
    logic [63:0] result;
    result = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [63:0] fill_pattern(input int w);
    logic [7:0] b;
    b = 8'(w);
    return {b, ~b, 16'h3c96, b ^ 8'h5a, b, 8'(w * 7), 8'(w + 17)};
  endfunction

  task automatic issue(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
    int w;
    expect_type e;
    @(posedge clock);
    #2;
    valid = 1'b1;
    addr = a;
    wdata = d;
    wstrb = s;
    w = word_of(a);
    if (s != 8'h00) begin
      model[w] = apply_strobe(model[w], d, s);
      e.is_read = 1'b0;
      e.value = '0;
    end else begin
      e.is_read = 1'b1;
      e.value = model[w]; // value as of issue time
    end
    pending.push_back(e);
  endtask

  task automatic idle();
    @(posedge clock);
    #2;
    valid = 1'b0;
    wstrb = 8'h00;
  endtask

  task automatic drain();
    int n;
    idle();
    n = 0;
    while (pending.size() != 0 && n < timeout_cycles) begin
      @(posedge clock);
      n++;
    end
    if (pending.size() != 0) begin
      $display("timeout after %0d cycles waiting for %0d responses in test %s",
               timeout_cycles, pending.size(), test_name);
      check_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic check_idle();
    assert (ready == 1'b0 && rdata == '0) else begin
      $display("FAILED %s expected ready 0 rdata %h actual ready %b rdata %h",
               test_name, 64'h0, ready, rdata);
      check_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = check_errors;
  endtask

  task automatic end_test();
    if (check_errors == errors_at_start) begin
      tests_passed++;
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, check_errors - errors_at_start);
    end
  endtask

  task automatic test_reset_idle();
    repeat (8) begin
      @(negedge clock);
      check_idle();
    end
    @(posedge clock);
    #2;
    valid = 1'b1; // reads during reset must be dropped
    addr = 32'h0000_0128;
    repeat (6) begin
      @(negedge clock);
      check_idle();
    end
    @(posedge clock);
    #2;
    valid = 1'b0;
    @(negedge clock);
    check_idle();
    @(posedge clock);
    #2;
    reset = 1'b1;
    repeat (4) begin
      @(negedge clock);
      check_idle();
    end
  endtask

  task automatic test_full_word();
    for (int w = 0; w < words; w++) begin
      issue(32'(w) << 3, fill_pattern(w), 8'hff);
    end
    drain();
    if (timed_out) return;
    for (int w = 0; w < words; w++) begin
      issue(32'(w) << 3, '0, 8'h00);
    end
    drain();
  endtask

  task automatic test_strobes();
    logic [31:0] a;
    a = 32'h0000_0128; // bank 1, index 9
    issue(a, 64'h0123_4567_89ab_cdef, 8'hff);
    for (int b = 0; b < 8; b++) begin
      issue(a, {$urandom, $urandom}, 8'(1 << b));
      idle();
      issue(a, '0, 8'h00);
    end
    issue(a, {$urandom, $urandom}, 8'h0f);
    issue(a + 32'h20, {$urandom, $urandom}, 8'hf0);
    issue(a, {$urandom, $urandom}, 8'h5a);
    idle();
    issue(a + 32'h20, {$urandom, $urandom}, 8'h81);
    idle();
    issue(a, '0, 8'h00);
    issue(a + 32'h20, '0, 8'h00);
    drain();
  endtask

  task automatic test_back_to_back();
    logic [31:0] a;
    a = 32'h0000_0350;
    issue(a, 64'hfeed_0001_cafe_0002, 8'hff);
    issue(a, '0, 8'h00); // forwarded full word
    issue(a + 32'h40, 64'h1111_2222_3333_4444, 8'h0f);
    issue(a + 32'h40, 64'h5555_6666_7777_8888, 8'hf0);
    issue(a + 32'h40, '0, 8'h00);
    issue(a, 64'h9999_aaaa_bbbb_cccc, 8'h3c);
    issue(a, '0, 8'h00);
    issue(a, 64'hdddd_eeee_ffff_0000, 8'hc3);
    issue(a, '0, 8'h00);
    issue(a, 64'h0a0a_0a0a_0a0a_0a0a, 8'hff);
    issue(a + 32'h08, 64'h0b0b_0b0b_0b0b_0b0b, 8'hff); // same index, next bank
    issue(a, '0, 8'h00);
    issue(a + 32'h08, '0, 8'h00);
    drain();
  endtask

  task automatic test_aliasing();
    logic [31:0] a;
    a = 32'h0000_04a0;
    issue(a, 64'h7766_5544_3322_1100, 8'hff);
    issue(a | 32'h0000_0005, '0, 8'h00); // byte offset
    issue(a | 32'h0000_0800, '0, 8'h00); // above index field
    issue(a | 32'hfff0_0803, 64'h00ff_00ff_00ff_00ff, 8'h33);
    idle();
    issue(a, '0, 8'h00);
    issue(a | 32'h8000_0007, '0, 8'h00);
    drain();
  endtask

  task automatic test_random();
    logic [31:0] a;
    logic [7:0] s;
    for (int n = 0; n < 400; n++) begin
      a = $urandom;
      if ($urandom_range(1, 0) == 1) begin
        a[10:3] = 8'($urandom_range(5, 0)); // crowd a few words for forwarding hits
      end
      if ($urandom_range(1, 0) == 1) begin
        s = 8'($urandom_range(255, 1));
      end else begin
        s = 8'h00;
      end
      issue(a, {$urandom, $urandom}, s);
      if ($urandom_range(3, 0) == 0) begin
        idle();
      end
    end
    drain();
  endtask

  task automatic run_tests();
    start_test("reset_idle");
    test_reset_idle();
    end_test();
    start_test("full_word");
    test_full_word();
    end_test();
    if (timed_out) return;
    start_test("byte_strobe");
    test_strobes();
    end_test();
    if (timed_out) return;
    start_test("back_to_back");
    test_back_to_back();
    end_test();
    if (timed_out) return;
    start_test("aliasing");
    test_aliasing();
    end_test();
    if (timed_out) return;
    start_test("random");
    test_random();
    end_test();
  endtask

  initial begin
    void'($urandom(29132));
    reset = 1'b0;
    valid = 1'b0;
    addr = '0;
    wdata = '0;
    wstrb = '0;
    run_tests();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verif/tim_asserts.sv */
`timescale 1ns/100ps

module tim_asserts #(
  parameter int tim_width = 4
) (
  input logic clock,
  input logic reset,
  input logic valid,
  input logic ready,
  input logic [7:0] wstrb,
  input logic [63:0] rdata,
  input logic bank_wen [tim_width]
);

  logic any_wen;
  logic started = 1'b0; // no history before the first edge

  always_comb begin
    any_wen = 1'b0;
    for (int i = 0; i < tim_width; i++) begin
      any_wen = any_wen | bank_wen[i];
    end
  end

  always_ff @(posedge clock) begin
    started <= 1'b1;
  end

  // one cycle response without back-pressure
  ready_follows_valid: assert property (
    @(posedge clock) started && $past(reset) |-> ready == $past(valid)
  ) else $error("ready is not valid delayed by one cycle");

  // a read is a request with all strobes clear
  rdata_zero_unless_read: assert property (
    @(posedge clock) started && !($past(reset) && $past(valid) && $past(wstrb) == 8'h00)
      |-> rdata == '0
  ) else $error("rdata is nonzero while no read is answered");

  no_write_while_idle: assert property (
    @(posedge clock) !ready |-> !any_wen
  ) else $error("bank write enabled while ready is low");

  ready_low_after_reset: assert property (
    @(posedge clock) started && !$past(reset) |-> !ready
  ) else $error("ready is high in the cycle after reset");

endmodule

bind tim tim_asserts #(
  .tim_width(tim_width)
) asserts (
  .clock(clock),
  .reset(reset),
  .valid(valid),
  .ready(ready),
  .wstrb(wstrb),
  .rdata(rdata),
  .bank_wen(bank_wen)
);

/* source/tim.sv */
`timescale 1ns/100ps

module tim
  import tim_pkg::*;
#(
  parameter int tim_depth = 256,
  parameter int tim_width = 4
) (
  input logic clock,
  input logic reset,
  input logic valid,
  input logic [31:0] addr,
  input logic [63:0] wdata,
  input logic [7:0] wstrb,
  output logic [63:0] rdata,
  output logic ready
);

  mem_in_type request;
  mem_out_type response;
  tim_front_type front;

  logic [tim_index_bits-1:0] bank_raddr [tim_width];
  logic bank_wen [tim_width];
  logic [tim_index_bits-1:0] bank_waddr [tim_width];
  logic [63:0] bank_wdata [tim_width];
  tim_ram_out_type bank_out [tim_width];

  assign request.mem_valid = valid;
  assign request.mem_addr = addr;
  assign request.mem_wdata = wdata;
  assign request.mem_wstrb = wstrb;

  assign rdata = response.mem_rdata;
  assign ready = response.mem_ready;

  tim_decode #(
    .tim_depth(tim_depth),
    .tim_width(tim_width)
  ) decode (
    .clock(clock),
    .reset(reset),
    .request(request),
    .front(front),
    .bank_raddr(bank_raddr)
  );

  tim_merge #(
    .tim_depth(tim_depth),
    .tim_width(tim_width)
  ) merge (
    .clock(clock),
    .reset(reset),
    .front(front),
    .bank_out(bank_out),
    .bank_wen(bank_wen),
    .bank_waddr(bank_waddr),
    .bank_wdata(bank_wdata),
    .response(response)
  );

  for (genvar i = 0; i < tim_width; i++) begin : bank
    tim_ram_in_type ram_in;
    tim_ram_out_type ram_out;

    // read side from decode, write side from merge
    assign ram_in.wen = bank_wen[i];
    assign ram_in.waddr = bank_waddr[i];
    assign ram_in.raddr = bank_raddr[i];
    assign ram_in.wdata = bank_wdata[i];
    assign bank_out[i] = ram_out;

    tim_ram #(
      .tim_depth(tim_depth)
    ) ram (
      .clock(clock),
      .ram_in(ram_in),
      .ram_out(ram_out)
    );
  end

endmodule

/* source/tim_merge.sv */
`timescale 1ns/100ps

module tim_merge
  import tim_pkg::*;
#(
  parameter int tim_depth = 256,
  parameter int tim_width = 4
) (
  input logic clock,
  input logic reset,
  input tim_front_type front,
  input tim_ram_out_type bank_out [tim_width],
  output logic bank_wen [tim_width],
  output logic [tim_index_bits-1:0] bank_waddr [tim_width],
  output logic [63:0] bank_wdata [tim_width],
  output mem_out_type response
);

  localparam int index_bits = $clog2(tim_depth);
  localparam int bank_bits = $clog2(tim_width);

  tim_back_type back;
  tim_back_type back_next;

  logic [bank_bits-1:0] front_bank;
  logic [bank_bits-1:0] back_bank;
  logic [index_bits-1:0] front_index;
  logic [index_bits-1:0] back_index;

  logic hit;
  logic [63:0] old_word;
  logic [63:0] merged_word;

  assign front_bank = front.bank[bank_bits-1:0];
  assign back_bank = back.bank[bank_bits-1:0];
  assign front_index = front.index[index_bits-1:0];
  assign back_index = back.index[index_bits-1:0];

  // previous access wrote this word on the edge the bank was read
  assign hit = back.enable && (back_bank == front_bank) && (back_index == front_index);

  always_comb begin
    if (hit) begin
      old_word = back.data; // forwarded
    end else begin
      old_word = bank_out[front_bank].rdata;
    end
  end

  always_comb begin
    for (int b = 0; b < 8; b++) begin
      if (front.strb[b]) begin
        merged_word[8*b +: 8] = front.data[8*b +: 8];
      end else begin
        merged_word[8*b +: 8] = old_word[8*b +: 8];
      end
    end
  end

  // write back to the addressed bank only
  always_comb begin
    for (int i = 0; i < tim_width; i++) begin
      if (front_bank == bank_bits'(i)) begin
        bank_wen[i] = front.wren;
        bank_waddr[i] = front.index;
        bank_wdata[i] = merged_word;
      end else begin
        bank_wen[i] = 1'b0;
        bank_waddr[i] = '0;
        bank_wdata[i] = '0;
      end
    end
  end

  always_comb begin
    response.mem_ready = front.enable;
    if (front.rden) begin
      response.mem_rdata = old_word;
    end else begin
      response.mem_rdata = '0; // writes answer with zero
    end
  end

  always_comb begin
    back_next.enable = front.enable;
    back_next.wren = front.wren;
    back_next.rden = front.rden;
    back_next.bank = front.bank;
    back_next.index = front.index;
    back_next.strb = front.strb;
    back_next.data = merged_word; // equals old word on reads
    back_next.rdata = old_word;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      back <= '0;
    end else begin
      back <= back_next;
    end
  end

endmodule

/* source/tim_decode.sv */
`timescale 1ns/100ps

module tim_decode
  import tim_pkg::*;
#(
  parameter int tim_depth = 256,
  parameter int tim_width = 4
) (
  input logic clock,
  input logic reset,
  input mem_in_type request,
  output tim_front_type front,
  output logic [tim_index_bits-1:0] bank_raddr [tim_width]
);

  localparam int index_bits = $clog2(tim_depth);
  localparam int bank_bits = $clog2(tim_width);

  // field positions in the byte address
  localparam int bank_lsb = 3;
  localparam int index_lsb = bank_lsb + bank_bits;

  logic [bank_bits-1:0] addr_bank;
  logic [index_bits-1:0] addr_index;
  logic is_write;

  tim_front_type front_next;

  assign addr_bank = request.mem_addr[index_lsb-1:bank_lsb];
  assign addr_index = request.mem_addr[index_lsb+index_bits-1:index_lsb];
  assign is_write = |request.mem_wstrb; // any strobe means write

  always_comb begin
    front_next = front;
    front_next.enable = 1'b0;
    front_next.wren = 1'b0;
    front_next.rden = 1'b0;
    if (request.mem_valid) begin
      front_next.enable = 1'b1;
      front_next.wren = is_write;
      front_next.rden = ~is_write;
      front_next.bank = tim_bank_bits'(addr_bank);
      front_next.index = tim_index_bits'(addr_index);
      front_next.data = request.mem_wdata;
      front_next.strb = request.mem_wstrb;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      front <= '0;
    end else begin
      front <= front_next;
    end
  end

  // bank read starts with the request, data lands with front
  always_comb begin
    for (int i = 0; i < tim_width; i++) begin
      if (addr_bank == bank_bits'(i)) begin
        bank_raddr[i] = tim_index_bits'(addr_index);
      end else begin
        bank_raddr[i] = '0; // idle banks
      end
    end
  end

endmodule

/* source/tim_ram.sv */
`timescale 1ns/100ps

module tim_ram
  import tim_pkg::*;
#(
  parameter int tim_depth = 256
) (
  input logic clock,
  input tim_ram_in_type ram_in,
  output tim_ram_out_type ram_out
);

  localparam int depth_bits = $clog2(tim_depth);

  logic [63:0] mem [tim_depth] = '{default: '0};

  logic [depth_bits-1:0] waddr;
  logic [depth_bits-1:0] raddr;

  assign waddr = ram_in.waddr[depth_bits-1:0];
  assign raddr = ram_in.raddr[depth_bits-1:0];

  always_ff @(posedge clock) begin
    if (ram_in.wen) begin
      mem[waddr] <= ram_in.wdata;
    end
  end

  // read before write on the same edge
  always_ff @(posedge clock) begin
    ram_out.rdata <= mem[raddr];
  end

endmodule

/* source/tim_pkg.sv */
package tim_pkg;

  // modules use only the low bits of these upper bounds
  localparam int tim_index_bits = 16;
  localparam int tim_bank_bits = 4;

  // bus request from the core
  typedef struct packed {
    logic mem_valid;
    logic [31:0] mem_addr;
    logic [63:0] mem_wdata;
    logic [7:0] mem_wstrb;
  } mem_in_type;

  // bus response to the core
  typedef struct packed {
    logic mem_ready;
    logic [63:0] mem_rdata;
  } mem_out_type;

  typedef struct packed {
    logic wen;
    logic [tim_index_bits-1:0] waddr;
    logic [tim_index_bits-1:0] raddr;
    logic [63:0] wdata;
  } tim_ram_in_type;

  typedef struct packed {
    logic [63:0] rdata;
  } tim_ram_out_type;

  // decode stage register
  typedef struct packed {
    logic enable;
    logic wren;
    logic rden;
    logic [tim_bank_bits-1:0] bank;
    logic [tim_index_bits-1:0] index;
    logic [63:0] data;
    logic [7:0] strb;
  } tim_front_type;

  // merge stage register with the merged word in data
  typedef struct packed {
    logic enable;
    logic wren;
    logic rden;
    logic [tim_bank_bits-1:0] bank;
    logic [tim_index_bits-1:0] index;
    logic [63:0] data;
    logic [7:0] strb;
    logic [63:0] rdata;
  } tim_back_type;

endpackage
